// ==== rtl/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus geometry
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 64
`define SOC_ID_WIDTH 4
`define SOC_LEN_WIDTH 8

// main ram region
`define SOC_RAM_BASE 32'h1c00_0000
`define SOC_RAM_ADDR_BITS 16

// video ram region
`define SOC_VGA_BASE 32'h0001_0000
`define SOC_VGA_ADDR_BITS 11

`endif

// ==== rtl/soc_pkg.sv ====
package soc_pkg;

   // encodings as on the AXI wires
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      DECERR = 2'b11
   } axi_resp_e;

   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_e;

   // sram bridge sequencing
   typedef enum logic [2:0] {
      IDLE,
      RD_ADDR,
      RD_DATA,
      WR_DATA,
      WR_RESP
   } bridge_state_e;

endpackage

// ==== rtl/axi_if.sv ====
`include "soc_defines.svh"

interface axi_if;
   import soc_pkg::*;

   // write address
   logic [`SOC_ID_WIDTH-1:0]       awid;
   logic [`SOC_ADDR_WIDTH-1:0]     awaddr;
   logic [`SOC_LEN_WIDTH-1:0]      awlen;
   axi_burst_e                     awburst;
   logic                           awvalid;
   logic                           awready;

   // write data
   logic [`SOC_DATA_WIDTH-1:0]     wdata;
   logic [`SOC_DATA_WIDTH/8-1:0]   wstrb;
   logic                           wlast;
   logic                           wvalid;
   logic                           wready;

   // write response
   logic [`SOC_ID_WIDTH-1:0]       bid;
   axi_resp_e                      bresp;
   logic                           bvalid;
   logic                           bready;

   // read address
   logic [`SOC_ID_WIDTH-1:0]       arid;
   logic [`SOC_ADDR_WIDTH-1:0]     araddr;
   logic [`SOC_LEN_WIDTH-1:0]      arlen;
   axi_burst_e                     arburst;
   logic                           arvalid;
   logic                           arready;

   // read data
   logic [`SOC_ID_WIDTH-1:0]       rid;
   logic [`SOC_DATA_WIDTH-1:0]     rdata;
   axi_resp_e                      rresp;
   logic                           rlast;
   logic                           rvalid;
   logic                           rready;

   modport master (
      output awid, awaddr, awlen, awburst, awvalid, wdata, wstrb, wlast, wvalid, bready,
      output arid, araddr, arlen, arburst, arvalid, rready,
      input  awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rlast, rvalid
   );

   modport slave (
      input  awid, awaddr, awlen, awburst, awvalid, wdata, wstrb, wlast, wvalid, bready,
      input  arid, araddr, arlen, arburst, arvalid, rready,
      output awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rlast, rvalid
   );

endinterface

// ==== rtl/sram.sv ====
`include "soc_defines.svh"

module sram #(
   parameter int WORD_BITS = 13
) (
   input  logic                          clk,
   input  logic [WORD_BITS-1:0]          addr,
   input  logic [`SOC_DATA_WIDTH-1:0]    wdata,
   input  logic [`SOC_DATA_WIDTH/8-1:0]  wen,
   input  logic                          ren,
   output logic [`SOC_DATA_WIDTH-1:0]    rdata
);

   logic [`SOC_DATA_WIDTH-1:0] mem [2**WORD_BITS];

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `SOC_DATA_WIDTH/8; i++)
      begin
         if (wen[i])
            mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
      // output holds between reads
      if (ren)
         rdata <= mem[addr];
   end

endmodule

// ==== rtl/axi_sram_bridge.sv ====
`include "soc_defines.svh"

module axi_sram_bridge #(
   parameter int WORD_BITS = 13
) (
   input  logic                          clk,
   input  logic                          resetn,
   axi_if.slave                          bus,
   output logic [WORD_BITS-1:0]          ram_addr,
   output logic [`SOC_DATA_WIDTH-1:0]    ram_wdata,
   output logic [`SOC_DATA_WIDTH/8-1:0]  ram_wen,
   output logic                          ram_ren,
   input  logic [`SOC_DATA_WIDTH-1:0]    ram_rdata
);
   import soc_pkg::*;

   bridge_state_e              state;
   logic [`SOC_ID_WIDTH-1:0]   id_q;
   logic [WORD_BITS-1:0]       addr_q;
   logic [`SOC_LEN_WIDTH-1:0]  cnt_q;
   axi_burst_e                 burst_q;
   logic                       ar_hs;
   logic                       aw_hs;
   logic                       w_hs;
   logic                       r_hs;
   logic                       b_hs;

   assign ar_hs = bus.arvalid && bus.arready;
   assign aw_hs = bus.awvalid && bus.awready;
   assign w_hs  = bus.wvalid && bus.wready;
   assign r_hs  = bus.rvalid && bus.rready;
   assign b_hs  = bus.bvalid && bus.bready;

   // reads take priority when both arrive together
   assign bus.arready = (state == IDLE);
   assign bus.awready = (state == IDLE) && !bus.arvalid;
   assign bus.wready  = (state == WR_DATA);

   assign bus.bvalid  = (state == WR_RESP);
   assign bus.bid     = id_q;
   assign bus.bresp   = OKAY;

   assign bus.rvalid  = (state == RD_DATA);
   assign bus.rid     = id_q;
   assign bus.rdata   = ram_rdata;
   assign bus.rresp   = OKAY;
   assign bus.rlast   = (state == RD_DATA) && (cnt_q == '0);

   // one port serves both directions
   assign ram_addr  = addr_q;
   assign ram_ren   = (state == RD_ADDR);
   assign ram_wdata = bus.wdata;
   assign ram_wen   = w_hs ? bus.wstrb : '0;

   always_ff @(posedge clk)
   begin
      if (!resetn)
         state <= IDLE;
      else
      begin
         case (state)
            IDLE:
            begin
               if (ar_hs)
                  state <= RD_ADDR;
               else if (aw_hs)
                  state <= WR_DATA;
            end
            RD_ADDR:
               state <= RD_DATA;
            RD_DATA:
            begin
               if (r_hs)
                  state <= (cnt_q == '0) ? IDLE : RD_ADDR;
            end
            WR_DATA:
            begin
               if (w_hs && bus.wlast)
                  state <= WR_RESP;
            end
            WR_RESP:
            begin
               if (b_hs)
                  state <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // burst context, cnt_q counts beats still to go
   always_ff @(posedge clk)
   begin
      if (ar_hs)
      begin
         id_q    <= bus.arid;
         addr_q  <= bus.araddr[WORD_BITS+2:3];
         cnt_q   <= bus.arlen;
         burst_q <= bus.arburst;
      end
      else if (aw_hs)
      begin
         id_q    <= bus.awid;
         addr_q  <= bus.awaddr[WORD_BITS+2:3];
         cnt_q   <= bus.awlen;
         burst_q <= bus.awburst;
      end
      else if (r_hs || w_hs)
      begin
         cnt_q <= cnt_q - 1'b1;
         if (burst_q == INCR)
            addr_q <= addr_q + 1'b1;
      end
   end

   a_wlast_on_final: assert property (@(posedge clk) disable iff (!resetn)
      w_hs |-> (bus.wlast == (cnt_q == '0)));

   a_r_stable: assert property (@(posedge clk) disable iff (!resetn)
      bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata) && $stable(bus.rlast));

endmodule

// ==== rtl/axi_addr_decoder.sv ====
`include "soc_defines.svh"

module axi_addr_decoder (
   input  logic   clk,
   input  logic   resetn,
   axi_if.slave   up,
   axi_if.master  ram,
   axi_if.master  vga
);
   import soc_pkg::*;

   localparam logic [`SOC_ADDR_WIDTH-1:0] RAM_BASE = `SOC_RAM_BASE;
   localparam logic [`SOC_ADDR_WIDTH-1:0] VGA_BASE = `SOC_VGA_BASE;

   logic                       ar_ram;
   logic                       ar_vga;
   logic                       aw_ram;
   logic                       aw_vga;
   logic                       rd_busy;
   logic                       rd_ram;
   logic                       rd_vga;
   logic [`SOC_ID_WIDTH-1:0]   rd_id;
   logic [`SOC_LEN_WIDTH-1:0]  rd_cnt;
   logic                       wr_busy;
   logic                       wr_ram;
   logic                       wr_vga;
   logic                       wr_bpend;
   logic [`SOC_ID_WIDTH-1:0]   wr_id;
   logic                       up_ar_hs;
   logic                       up_aw_hs;
   logic                       up_r_hs;
   logic                       up_r_done;
   logic                       up_w_hs;
   logic                       up_b_done;

   // upper address bits must match the region base
   function automatic logic region_hit(input logic [`SOC_ADDR_WIDTH-1:0] addr,
                                       input logic [`SOC_ADDR_WIDTH-1:0] base,
                                       input int bits);
      return (addr >> bits) == (base >> bits);
   endfunction

   assign ar_ram = region_hit(up.araddr, RAM_BASE, `SOC_RAM_ADDR_BITS);
   assign ar_vga = region_hit(up.araddr, VGA_BASE, `SOC_VGA_ADDR_BITS);
   assign aw_ram = region_hit(up.awaddr, RAM_BASE, `SOC_RAM_ADDR_BITS);
   assign aw_vga = region_hit(up.awaddr, VGA_BASE, `SOC_VGA_ADDR_BITS);

   assign up_ar_hs  = up.arvalid && up.arready;
   assign up_aw_hs  = up.awvalid && up.awready;
   assign up_r_hs   = up.rvalid && up.rready;
   assign up_r_done = up_r_hs && up.rlast;
   assign up_w_hs   = up.wvalid && up.wready;
   assign up_b_done = up.bvalid && up.bready;

   // read address, unmapped requests are taken at once
   assign ram.arvalid = up.arvalid && !rd_busy && ar_ram;
   assign vga.arvalid = up.arvalid && !rd_busy && ar_vga;
   assign up.arready  = !rd_busy && (ar_ram ? ram.arready : (ar_vga ? vga.arready : 1'b1));
   assign ram.arid    = up.arid;
   assign ram.araddr  = up.araddr;
   assign ram.arlen   = up.arlen;
   assign ram.arburst = up.arburst;
   assign vga.arid    = up.arid;
   assign vga.araddr  = up.araddr;
   assign vga.arlen   = up.arlen;
   assign vga.arburst = up.arburst;

   // write address and data
   assign ram.awvalid = up.awvalid && !wr_busy && aw_ram;
   assign vga.awvalid = up.awvalid && !wr_busy && aw_vga;
   assign up.awready  = !wr_busy && (aw_ram ? ram.awready : (aw_vga ? vga.awready : 1'b1));
   assign ram.awid    = up.awid;
   assign ram.awaddr  = up.awaddr;
   assign ram.awlen   = up.awlen;
   assign ram.awburst = up.awburst;
   assign vga.awid    = up.awid;
   assign vga.awaddr  = up.awaddr;
   assign vga.awlen   = up.awlen;
   assign vga.awburst = up.awburst;
   assign ram.wvalid  = up.wvalid && wr_busy && wr_ram;
   assign vga.wvalid  = up.wvalid && wr_busy && wr_vga;
   assign ram.wdata   = up.wdata;
   assign ram.wstrb   = up.wstrb;
   assign ram.wlast   = up.wlast;
   assign vga.wdata   = up.wdata;
   assign vga.wstrb   = up.wstrb;
   assign vga.wlast   = up.wlast;

   assign ram.rready = up.rready && rd_ram;
   assign vga.rready = up.rready && rd_vga;
   assign ram.bready = up.bready && wr_ram;
   assign vga.bready = up.bready && wr_vga;

   // return channels, falling back to decode error beats
   always_comb
   begin
      up.rvalid = rd_busy;
      up.rid    = rd_id;
      up.rdata  = '0;
      up.rresp  = DECERR;
      up.rlast  = (rd_cnt == '0);
      if (rd_ram)
      begin
         up.rvalid = ram.rvalid;
         up.rid    = ram.rid;
         up.rdata  = ram.rdata;
         up.rresp  = ram.rresp;
         up.rlast  = ram.rlast;
      end
      else if (rd_vga)
      begin
         up.rvalid = vga.rvalid;
         up.rid    = vga.rid;
         up.rdata  = vga.rdata;
         up.rresp  = vga.rresp;
         up.rlast  = vga.rlast;
      end
   end

   always_comb
   begin
      up.wready = wr_busy && !wr_bpend;
      up.bvalid = wr_bpend;
      up.bid    = wr_id;
      up.bresp  = DECERR;
      if (wr_ram)
      begin
         up.wready = ram.wready;
         up.bvalid = ram.bvalid;
         up.bid    = ram.bid;
         up.bresp  = ram.bresp;
      end
      else if (wr_vga)
      begin
         up.wready = vga.wready;
         up.bvalid = vga.bvalid;
         up.bid    = vga.bid;
         up.bresp  = vga.bresp;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         rd_busy  <= 1'b0;
         rd_ram   <= 1'b0;
         rd_vga   <= 1'b0;
         wr_busy  <= 1'b0;
         wr_ram   <= 1'b0;
         wr_vga   <= 1'b0;
         wr_bpend <= 1'b0;
      end
      else
      begin
         if (up_ar_hs)
         begin
            rd_busy <= 1'b1;
            rd_ram  <= ar_ram;
            rd_vga  <= ar_vga;
         end
         else if (up_r_done)
            rd_busy <= 1'b0;

         if (up_aw_hs)
         begin
            wr_busy <= 1'b1;
            wr_ram  <= aw_ram;
            wr_vga  <= aw_vga;
         end
         else if (up_b_done)
         begin
            wr_busy  <= 1'b0;
            wr_bpend <= 1'b0;
         end
         else if (up_w_hs && up.wlast && !wr_ram && !wr_vga)
            wr_bpend <= 1'b1;
      end
   end

   // decode error context
   always_ff @(posedge clk)
   begin
      if (up_ar_hs)
      begin
         rd_id  <= up.arid;
         rd_cnt <= up.arlen;
      end
      else if (up_r_hs)
         rd_cnt <= rd_cnt - 1'b1;
      if (up_aw_hs)
         wr_id <= up.awid;
   end

   a_one_read: assert property (@(posedge clk) disable iff (!resetn)
      up_ar_hs |=> !up_ar_hs until_with up_r_done);

   a_one_write: assert property (@(posedge clk) disable iff (!resetn)
      up_aw_hs |=> !up_aw_hs until_with up_b_done);

   a_no_wrap: assert property (@(posedge clk) disable iff (!resetn)
      !(up_ar_hs && up.arburst == WRAP) && !(up_aw_hs && up.awburst == WRAP));

endmodule

// ==== rtl/soc_mem_top.sv ====
`include "soc_defines.svh"

module soc_mem_top (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic [`SOC_ID_WIDTH-1:0]      awid,
   input  logic [`SOC_ADDR_WIDTH-1:0]    awaddr,
   input  logic [`SOC_LEN_WIDTH-1:0]     awlen,
   input  soc_pkg::axi_burst_e           awburst,
   input  logic                          awvalid,
   output logic                          awready,
   input  logic [`SOC_DATA_WIDTH-1:0]    wdata,
   input  logic [`SOC_DATA_WIDTH/8-1:0]  wstrb,
   input  logic                          wlast,
   input  logic                          wvalid,
   output logic                          wready,
   output logic [`SOC_ID_WIDTH-1:0]      bid,
   output soc_pkg::axi_resp_e            bresp,
   output logic                          bvalid,
   input  logic                          bready,
   input  logic [`SOC_ID_WIDTH-1:0]      arid,
   input  logic [`SOC_ADDR_WIDTH-1:0]    araddr,
   input  logic [`SOC_LEN_WIDTH-1:0]     arlen,
   input  soc_pkg::axi_burst_e           arburst,
   input  logic                          arvalid,
   output logic                          arready,
   output logic [`SOC_ID_WIDTH-1:0]      rid,
   output logic [`SOC_DATA_WIDTH-1:0]    rdata,
   output soc_pkg::axi_resp_e            rresp,
   output logic                          rlast,
   output logic                          rvalid,
   input  logic                          rready
);

   // word address widths, byte offset dropped
   localparam int RAM_WORD_BITS = `SOC_RAM_ADDR_BITS - 3;
   localparam int VGA_WORD_BITS = `SOC_VGA_ADDR_BITS - 3;

   logic [RAM_WORD_BITS-1:0]      ram_addr;
   logic [`SOC_DATA_WIDTH-1:0]    ram_wdata;
   logic [`SOC_DATA_WIDTH/8-1:0]  ram_wen;
   logic                          ram_ren;
   logic [`SOC_DATA_WIDTH-1:0]    ram_rdata;
   logic [VGA_WORD_BITS-1:0]      vga_addr;
   logic [`SOC_DATA_WIDTH-1:0]    vga_wdata;
   logic [`SOC_DATA_WIDTH/8-1:0]  vga_wen;
   logic                          vga_ren;
   logic [`SOC_DATA_WIDTH-1:0]    vga_rdata;

   axi_if up_bus ();
   axi_if ram_bus ();
   axi_if vga_bus ();

   assign up_bus.awid    = awid;
   assign up_bus.awaddr  = awaddr;
   assign up_bus.awlen   = awlen;
   assign up_bus.awburst = awburst;
   assign up_bus.awvalid = awvalid;
   assign up_bus.wdata   = wdata;
   assign up_bus.wstrb   = wstrb;
   assign up_bus.wlast   = wlast;
   assign up_bus.wvalid  = wvalid;
   assign up_bus.bready  = bready;
   assign up_bus.arid    = arid;
   assign up_bus.araddr  = araddr;
   assign up_bus.arlen   = arlen;
   assign up_bus.arburst = arburst;
   assign up_bus.arvalid = arvalid;
   assign up_bus.rready  = rready;

   assign awready = up_bus.awready;
   assign wready  = up_bus.wready;
   assign bid     = up_bus.bid;
   assign bresp   = up_bus.bresp;
   assign bvalid  = up_bus.bvalid;
   assign arready = up_bus.arready;
   assign rid     = up_bus.rid;
   assign rdata   = up_bus.rdata;
   assign rresp   = up_bus.rresp;
   assign rlast   = up_bus.rlast;
   assign rvalid  = up_bus.rvalid;

   axi_addr_decoder u_decoder (
      .clk    (clk),
      .resetn (resetn),
      .up     (up_bus),
      .ram    (ram_bus),
      .vga    (vga_bus)
   );

   axi_sram_bridge #(.WORD_BITS(RAM_WORD_BITS)) u_ram_bridge (
      .clk       (clk),
      .resetn    (resetn),
      .bus       (ram_bus),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_wen   (ram_wen),
      .ram_ren   (ram_ren),
      .ram_rdata (ram_rdata)
   );

   axi_sram_bridge #(.WORD_BITS(VGA_WORD_BITS)) u_vga_bridge (
      .clk       (clk),
      .resetn    (resetn),
      .bus       (vga_bus),
      .ram_addr  (vga_addr),
      .ram_wdata (vga_wdata),
      .ram_wen   (vga_wen),
      .ram_ren   (vga_ren),
      .ram_rdata (vga_rdata)
   );

   sram #(.WORD_BITS(RAM_WORD_BITS)) u_ram (
      .clk   (clk),
      .addr  (ram_addr),
      .wdata (ram_wdata),
      .wen   (ram_wen),
      .ren   (ram_ren),
      .rdata (ram_rdata)
   );

   sram #(.WORD_BITS(VGA_WORD_BITS)) u_vga (
      .clk   (clk),
      .addr  (vga_addr),
      .wdata (vga_wdata),
      .wen   (vga_wen),
      .ren   (vga_ren),
      .rdata (vga_rdata)
   );

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic resetn
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2) clk = ~clk;
   end

   // released on a rising edge
   initial
   begin
      resetn <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      resetn <= 1'b1;
   end

endmodule

// ==== verif/tb_soc_mem.sv ====
`include "soc_defines.svh"

module tb_soc_mem;
   timeunit 1ns;
   timeprecision 1ps;
   import soc_pkg::*;

   localparam int PERIOD_NS     = 40;
   localparam int RESET_CYCLES  = 16;
   localparam int WINDOW        = 64;
   localparam int N_INCR        = 6;
   localparam int MAX_LEN       = 16;
   localparam int PLANNED_BEATS = 2 * WINDOW + 3 + 2 * N_INCR * 2 * MAX_LEN + 14 + 12;
   localparam int WATCHDOG_NS   = (RESET_CYCLES + 20 * PLANNED_BEATS + 500) * PERIOD_NS;
   localparam int CH_AW = 0;
   localparam int CH_W  = 1;
   localparam int CH_AR = 2;
   localparam logic [`SOC_ADDR_WIDTH-1:0] RAM_BASE  = `SOC_RAM_BASE;
   localparam logic [`SOC_ADDR_WIDTH-1:0] VGA_BASE  = `SOC_VGA_BASE;
   localparam logic [`SOC_ADDR_WIDTH-1:0] HOLE_ADDR = 32'h2000_0000;

   typedef struct packed {
      logic [`SOC_DATA_WIDTH-1:0] data;
      axi_resp_e                  resp;
      logic [`SOC_ID_WIDTH-1:0]   id;
      logic                       last;
   } r_exp_t;

   typedef struct packed {
      axi_resp_e                  resp;
      logic [`SOC_ID_WIDTH-1:0]   id;
   } b_exp_t;

   logic                          clk;
   logic                          resetn;
   logic [`SOC_ID_WIDTH-1:0]      awid;
   logic [`SOC_ADDR_WIDTH-1:0]    awaddr;
   logic [`SOC_LEN_WIDTH-1:0]     awlen;
   axi_burst_e                    awburst;
   logic                          awvalid;
   logic                          awready;
   logic [`SOC_DATA_WIDTH-1:0]    wdata;
   logic [`SOC_DATA_WIDTH/8-1:0]  wstrb;
   logic                          wlast;
   logic                          wvalid;
   logic                          wready;
   logic [`SOC_ID_WIDTH-1:0]      bid;
   axi_resp_e                     bresp;
   logic                          bvalid;
   logic                          bready;
   logic [`SOC_ID_WIDTH-1:0]      arid;
   logic [`SOC_ADDR_WIDTH-1:0]    araddr;
   logic [`SOC_LEN_WIDTH-1:0]     arlen;
   axi_burst_e                    arburst;
   logic                          arvalid;
   logic                          arready;
   logic [`SOC_ID_WIDTH-1:0]      rid;
   logic [`SOC_DATA_WIDTH-1:0]    rdata;
   axi_resp_e                     rresp;
   logic                          rlast;
   logic                          rvalid;
   logic                          rready;

   logic [31:0]                   rng_state = 32'd39123;
   logic                          stall_on = 1'b1;
   string                         test_name = "reset";
   int                            data_errors;
   int                            resp_errors;
   int                            id_errors;
   int                            last_errors;
   int                            other_errors;
   logic [`SOC_DATA_WIDTH-1:0]    ram_model [int];
   logic [`SOC_DATA_WIDTH-1:0]    vga_model [int];
   r_exp_t                        r_exp_q [$];
   b_exp_t                        b_exp_q [$];

   tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
      .clk    (clk),
      .resetn (resetn)
   );

   soc_mem_top UUT (.*);

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [`SOC_ID_WIDTH-1:0] random_id();
      logic [31:0] r;
      r = next_random();
      return r[`SOC_ID_WIDTH-1:0];
   endfunction

   // 0 for main ram, 1 for video ram, -1 when unmapped
   function automatic int region_of(input logic [`SOC_ADDR_WIDTH-1:0] addr);
      if ((addr >> `SOC_RAM_ADDR_BITS) == (RAM_BASE >> `SOC_RAM_ADDR_BITS))
         return 0;
      if ((addr >> `SOC_VGA_ADDR_BITS) == (VGA_BASE >> `SOC_VGA_ADDR_BITS))
         return 1;
      return -1;
   endfunction

   // word offset of a beat, wrapping inside its region
   function automatic int beat_word(input logic [`SOC_ADDR_WIDTH-1:0] addr, input int beat,
                                    input axi_burst_e burst, input int region);
      int bits;
      int step;
      bits = (region == 0) ? `SOC_RAM_ADDR_BITS : `SOC_VGA_ADDR_BITS;
      step = (burst == INCR) ? beat : 0;
      return ((addr >> 3) + 32'(step)) % 32'(1 << (bits - 3));
   endfunction

   function automatic axi_resp_e ref_write(input logic [`SOC_ADDR_WIDTH-1:0] addr,
                                           input int beat, input axi_burst_e burst,
                                           input logic [`SOC_DATA_WIDTH-1:0] data,
                                           input logic [`SOC_DATA_WIDTH/8-1:0] strb);
      int region;
      int w;
      logic [`SOC_DATA_WIDTH-1:0] word;
      region = region_of(addr);
      if (region < 0)
         return DECERR;
      w = beat_word(addr, beat, burst, region);
      word = '0;
      if (region == 0 && ram_model.exists(w))
         word = ram_model[w];
      else if (region == 1 && vga_model.exists(w))
         word = vga_model[w];
      for (int b = 0; b < `SOC_DATA_WIDTH / 8; b++)
      begin
         if (strb[b])
            word[b*8 +: 8] = data[b*8 +: 8];
      end
      if (region == 0)
         ram_model[w] = word;
      else
         vga_model[w] = word;
      return OKAY;
   endfunction

   function automatic axi_resp_e ref_read(input logic [`SOC_ADDR_WIDTH-1:0] addr,
                                          input int beat, input axi_burst_e burst,
                                          output logic [`SOC_DATA_WIDTH-1:0] data);
      int region;
      int w;
      region = region_of(addr);
      data = '0;
      if (region < 0)
         return DECERR;
      w = beat_word(addr, beat, burst, region);
      if (region == 0 && ram_model.exists(w))
         data = ram_model[w];
      else if (region == 1 && vga_model.exists(w))
         data = vga_model[w];
      return OKAY;
   endfunction

   task automatic check_data(input logic [`SOC_DATA_WIDTH-1:0] expected,
                             input logic [`SOC_DATA_WIDTH-1:0] actual);
      if (actual !== expected)
      begin
         data_errors++;
         $display("[FAIL] %s: rdata expected %h, actual %h", test_name, expected, actual);
      end
   endtask

   task automatic check_resp(input string field, input axi_resp_e expected,
                             input axi_resp_e actual);
      if (actual !== expected)
      begin
         resp_errors++;
         $display("[FAIL] %s: %s expected %s, actual %s (%b)", test_name, field,
                  expected.name(), actual.name(), actual);
      end
   endtask

   task automatic check_id(input string field, input logic [`SOC_ID_WIDTH-1:0] expected,
                           input logic [`SOC_ID_WIDTH-1:0] actual);
      if (actual !== expected)
      begin
         id_errors++;
         $display("[FAIL] %s: %s expected %h, actual %h", test_name, field, expected, actual);
      end
   endtask

   task automatic check_last(input logic expected, input logic actual);
      if (actual !== expected)
      begin
         last_errors++;
         $display("[FAIL] %s: rlast expected %b, actual %b", test_name, expected, actual);
      end
   endtask

   task automatic report_other(input string msg);
      other_errors++;
      $display("%s: %s", test_name, msg);
   endtask

   // returns just after the edge on which the handshake completes
   task automatic wait_for_ready(input int chan);
      logic hs;
      do
      begin
         @(negedge clk);
         hs = (chan == CH_AW) ? awready : ((chan == CH_W) ? wready : arready);
         @(posedge clk);
      end
      while (!hs);
   endtask

   task automatic write_burst(input logic [`SOC_ID_WIDTH-1:0] id,
                              input logic [`SOC_ADDR_WIDTH-1:0] addr, input int len,
                              input axi_burst_e burst,
                              input logic [`SOC_DATA_WIDTH/8-1:0] strb, input logic rand_strb);
      logic [31:0] hi;
      logic [31:0] lo;
      logic [`SOC_DATA_WIDTH/8-1:0] s;
      axi_resp_e resp;
      b_exp_t be;
      resp = OKAY;
      awid    <= id;
      awaddr  <= addr;
      awlen   <= 8'(len);
      awburst <= burst;
      awvalid <= 1'b1;
      wait_for_ready(CH_AW);
      awvalid <= 1'b0;
      for (int i = 0; i <= len; i++)
      begin
         hi = next_random();
         lo = next_random();
         s = rand_strb ? 8'(next_random()) : strb;
         resp = ref_write(addr, i, burst, {hi, lo}, s);
         wdata  <= {hi, lo};
         wstrb  <= s;
         wlast  <= (i == len);
         wvalid <= 1'b1;
         wait_for_ready(CH_W);
      end
      wvalid <= 1'b0;
      wlast  <= 1'b0;
      be.resp = resp;
      be.id   = id;
      b_exp_q.push_back(be);
      while (b_exp_q.size() > 0)
         @(posedge clk);
   endtask

   task automatic read_burst(input logic [`SOC_ID_WIDTH-1:0] id,
                             input logic [`SOC_ADDR_WIDTH-1:0] addr, input int len,
                             input axi_burst_e burst, input logic streaming);
      r_exp_t re;
      logic [`SOC_DATA_WIDTH-1:0] d;
      for (int i = 0; i <= len; i++)
      begin
         re.resp = ref_read(addr, i, burst, d);
         re.data = d;
         re.id   = id;
         re.last = (i == len);
         r_exp_q.push_back(re);
      end
      arid    <= id;
      araddr  <= addr;
      arlen   <= 8'(len);
      arburst <= burst;
      arvalid <= 1'b1;
      wait_for_ready(CH_AR);
      arvalid <= 1'b0;
      // decode error beats come back to back under rready
      if (streaming)
      begin
         for (int i = 0; i <= len; i++)
         begin
            @(negedge clk);
            if (!(rvalid && rready))
               report_other($sformatf("decode-error beat %0d was not presented on its cycle", i));
            @(posedge clk);
         end
      end
      while (r_exp_q.size() > 0)
         @(posedge clk);
   endtask

   // response side back-pressure, drawn on the falling edge apart from the stimulus
   initial
   begin
      logic [31:0] r;
      logic rready_next;
      logic bready_next;
      rready <= 1'b0;
      bready <= 1'b0;
      forever
      begin
         @(negedge clk);
         r = next_random();
         rready_next = !stall_on || (r[1:0] != 2'b00);
         bready_next = !stall_on || (r[3:2] != 2'b00);
         @(posedge clk);
         rready <= rready_next;
         bready <= bready_next;
      end
   end

   always @(negedge clk)
   begin
      r_exp_t re;
      b_exp_t be;
      if (resetn && rvalid && rready)
      begin
         if (r_exp_q.size() == 0)
            report_other("a read beat arrived with no read outstanding");
         else
         begin
            re = r_exp_q.pop_front();
            check_data(re.data, rdata);
            check_resp("rresp", re.resp, rresp);
            check_id("rid", re.id, rid);
            check_last(re.last, rlast);
         end
      end
      if (resetn && bvalid && bready)
      begin
         if (b_exp_q.size() == 0)
            report_other("a write response arrived with no write outstanding");
         else
         begin
            be = b_exp_q.pop_front();
            check_resp("bresp", be.resp, bresp);
            check_id("bid", be.id, bid);
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      logic [`SOC_ADDR_WIDTH-1:0] base;
      int word;
      int len;
      int total;
      awid    <= '0;
      awaddr  <= '0;
      awlen   <= '0;
      awburst <= INCR;
      awvalid <= 1'b0;
      wdata   <= '0;
      wstrb   <= '0;
      wlast   <= 1'b0;
      wvalid  <= 1'b0;
      arid    <= '0;
      araddr  <= '0;
      arlen   <= '0;
      arburst <= INCR;
      arvalid <= 1'b0;
      wait (resetn === 1'b1);
      @(posedge clk);

      // full words first so later reads never see unwritten bytes
      test_name = "preload";
      write_burst(random_id(), RAM_BASE, WINDOW - 1, INCR, 8'hff, 1'b0);
      write_burst(random_id(), VGA_BASE, WINDOW - 1, INCR, 8'hff, 1'b0);

      test_name = "partial_strobe";
      write_burst(random_id(), RAM_BASE + 32'd80, 0, INCR, 8'hff, 1'b0);
      write_burst(random_id(), RAM_BASE + 32'd80, 0, INCR, 8'h3c, 1'b0);
      read_burst(random_id(), RAM_BASE + 32'd80, 0, INCR, 1'b0);

      test_name = "incr_bursts";
      for (int n = 0; n < 2 * N_INCR; n++)
      begin
         r = next_random();
         word = int'(r % 32'd48);
         r = next_random();
         len = int'(r % 32'(MAX_LEN));
         base = (n % 2 == 0) ? RAM_BASE : VGA_BASE;
         write_burst(random_id(), base + 32'(word * 8), len, INCR, 8'hff, 1'b1);
         read_burst(random_id(), base + 32'(word * 8), len, INCR, 1'b0);
      end

      test_name = "fixed_burst";
      write_burst(random_id(), RAM_BASE + 32'd160, 7, FIXED, 8'hff, 1'b1);
      read_burst(random_id(), RAM_BASE + 32'd160, 5, FIXED, 1'b0);

      test_name = "decode_error";
      stall_on = 1'b0;
      repeat (2) @(posedge clk);
      write_burst(random_id(), HOLE_ADDR, 3, INCR, 8'hff, 1'b1);
      read_burst(random_id(), HOLE_ADDR, 7, INCR, 1'b1);
      stall_on = 1'b1;

      repeat (4) @(posedge clk);
      total = data_errors + resp_errors + id_errors + last_errors + other_errors;
      $display("errors: data %0d, resp %0d, id %0d, last %0d, other %0d",
               data_errors, resp_errors, id_errors, last_errors, other_errors);
      if (total == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/soc_pkg.sv
rtl/axi_if.sv
rtl/sram.sv
rtl/axi_sram_bridge.sv
rtl/axi_addr_decoder.sv
rtl/soc_mem_top.sv
verif/tb_clock_gen.sv
verif/tb_soc_mem.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_soc_mem
RTL_TOP    ?= soc_mem_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
